//--- muldiv_pkg.sv
// shared types and helpers for the iterative multiply/divide unit
// operation encoding, engine FSM states and op decode functions

package muldiv_pkg;

  // --------------------------------------------------
  // operation encoding
  // --------------------------------------------------

  // two bits are enough for the four ops
  typedef enum logic [1:0] {
    op_mul  = 2'd0,
    op_mulu = 2'd1,
    op_div  = 2'd2,
    op_divu = 2'd3
  } muldiv_op_e;

  // --------------------------------------------------
  // engine FSM states
  // --------------------------------------------------

  // both engines walk idle -> calc -> done -> idle
  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_calc = 2'd1,
    st_done = 2'd2
  } engine_state_e;

  // --------------------------------------------------
  // op decode helpers
  // --------------------------------------------------

  // divide and remainder both go to the divider
  function automatic logic is_div_op(input muldiv_op_e op);
    return (op == op_div) || (op == op_divu);
  endfunction

  // signed ops need magnitude conversion and sign fix-up
  function automatic logic is_signed_op(input muldiv_op_e op);
    return (op == op_mul) || (op == op_div);
  endfunction

endpackage

//--- int_div_iterative.sv
`timescale 1ns/1ps
// iterative restoring divider engine
// returns {remainder, quotient} after WIDTH shift-subtract steps

module int_div_iterative #(
  parameter int WIDTH = 32
) (
  input  logic                   clk,
  input  logic                   reset,
  input  muldiv_pkg::muldiv_op_e req_op,
  input  logic [WIDTH-1:0]       req_a,
  input  logic [WIDTH-1:0]       req_b,
  input  logic                   req_val,
  output logic                   req_rdy,
  output logic [2*WIDTH-1:0]     resp_result,
  output muldiv_pkg::muldiv_op_e resp_op,
  output logic                   resp_val,
  input  logic                   resp_rdy
);

  // counter wide enough for WIDTH steps
  localparam int CNT_W = (WIDTH > 1) ? $clog2(WIDTH) : 1;

  // --------------------------------------------------
  // control state
  // --------------------------------------------------

  muldiv_pkg::engine_state_e state;
  logic [CNT_W-1:0]          count;
  logic                      last_step;
  logic                      req_go;
  logic                      resp_go;

  // --------------------------------------------------
  // payload registers
  // --------------------------------------------------

  muldiv_pkg::muldiv_op_e op_q;
  logic                   a_neg_q;
  logic                   b_neg_q;
  logic [WIDTH-1:0]       divisor_q;
  // remainder in the upper part, quotient shifts in at the bottom
  logic [2*WIDTH:0]       rq_q;

  // --------------------------------------------------
  // handshake
  // --------------------------------------------------

  assign req_rdy   = (state == muldiv_pkg::st_idle);
  assign resp_val  = (state == muldiv_pkg::st_done);
  assign req_go    = req_val && req_rdy;
  assign resp_go   = resp_val && resp_rdy;
  assign last_step = (count == CNT_W'(WIDTH - 1));

  // --------------------------------------------------
  // operand magnitudes on accept
  // --------------------------------------------------

  logic             req_signed;
  logic [WIDTH-1:0] a_mag;
  logic [WIDTH-1:0] b_mag;

  assign req_signed = muldiv_pkg::is_signed_op(req_op);
  // unsigned ops pass straight through
  assign a_mag = (req_signed && req_a[WIDTH-1]) ? (~req_a + 1'b1) : req_a;
  assign b_mag = (req_signed && req_b[WIDTH-1]) ? (~req_b + 1'b1) : req_b;

  // --------------------------------------------------
  // one restoring step
  // --------------------------------------------------

  logic [2*WIDTH:0] rq_shift;
  logic [2*WIDTH:0] sub_out;
  logic [2*WIDTH:0] rq_step;

  assign rq_shift = rq_q << 1;
  // divisor lines up with the remainder field
  assign sub_out  = rq_shift - {1'b0, divisor_q, {WIDTH{1'b0}}};
  // top bit set means the trial subtract went negative, so restore
  assign rq_step  = sub_out[2*WIDTH] ? rq_shift : {sub_out[2*WIDTH:1], 1'b1};

  // a zero divisor never fails the subtract
  // quotient fills with ones and the dividend ends up as remainder

  // --------------------------------------------------
  // sign fix-up in st_done
  // --------------------------------------------------

  logic             done_signed;
  logic             quot_neg;
  logic             rem_neg;
  logic [WIDTH-1:0] quot_mag;
  logic [WIDTH-1:0] rem_mag;

  assign quot_mag    = rq_q[WIDTH-1:0];
  assign rem_mag     = rq_q[2*WIDTH-1:WIDTH];
  assign done_signed = muldiv_pkg::is_signed_op(op_q);
  // quotient is negative when the operand signs differ
  assign quot_neg    = done_signed && (a_neg_q ^ b_neg_q);
  // remainder follows the dividend sign
  assign rem_neg     = done_signed && a_neg_q;

  assign resp_result = {rem_neg ? (~rem_mag + 1'b1) : rem_mag,
                        quot_neg ? (~quot_mag + 1'b1) : quot_mag};
  assign resp_op     = op_q;

  // --------------------------------------------------
  // FSM and iteration counter
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= muldiv_pkg::st_idle;
      count <= '0;
    end else begin
      case (state)
        muldiv_pkg::st_idle: begin
          if (req_go) begin
            state <= muldiv_pkg::st_calc;
            count <= '0;
          end
        end
        muldiv_pkg::st_calc: begin
          // WIDTH steps then the result is ready
          if (last_step) begin
            state <= muldiv_pkg::st_done;
          end
          count <= count + CNT_W'(1);
        end
        muldiv_pkg::st_done: begin
          // hold until the response leaves
          if (resp_go) begin
            state <= muldiv_pkg::st_idle;
          end
        end
        default: state <= muldiv_pkg::st_idle;
      endcase
    end
  end

  // datapath registers load on accept and step during calc
  always_ff @(posedge clk) begin
    if (req_go) begin
      op_q      <= req_op;
      a_neg_q   <= req_a[WIDTH-1];
      b_neg_q   <= req_b[WIDTH-1];
      divisor_q <= b_mag;
      rq_q      <= {{(WIDTH + 1){1'b0}}, a_mag};
    end else if (state == muldiv_pkg::st_calc) begin
      rq_q <= rq_step;
    end
  end

  // --------------------------------------------------
  // assertions
  // --------------------------------------------------

  // a response is offered WIDTH+1 clocks after its request was taken
  assert property (@(posedge clk) disable iff (reset)
    $rose(resp_val) |-> $past(req_go, WIDTH + 1));

  // a stalled response keeps its value and stays valid
  assert property (@(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> (resp_val && $stable(resp_result)));

endmodule

//--- int_mul_iterative.sv
`timescale 1ns/1ps
// iterative shift-add multiplier engine
// full 2*WIDTH product after WIDTH steps, sign applied at the end

module int_mul_iterative #(
  parameter int WIDTH = 32
) (
  input  logic                   clk,
  input  logic                   reset,
  input  muldiv_pkg::muldiv_op_e req_op,
  input  logic [WIDTH-1:0]       req_a,
  input  logic [WIDTH-1:0]       req_b,
  input  logic                   req_val,
  output logic                   req_rdy,
  output logic [2*WIDTH-1:0]     resp_result,
  output muldiv_pkg::muldiv_op_e resp_op,
  output logic                   resp_val,
  input  logic                   resp_rdy
);

  localparam int CNT_W = (WIDTH > 1) ? $clog2(WIDTH) : 1;

  // --------------------------------------------------
  // control
  // --------------------------------------------------

  muldiv_pkg::engine_state_e state;
  logic [CNT_W-1:0]          count;
  logic                      req_go;
  logic                      resp_go;

  assign req_rdy  = (state == muldiv_pkg::st_idle);
  assign resp_val = (state == muldiv_pkg::st_done);
  assign req_go   = req_val && req_rdy;
  assign resp_go  = resp_val && resp_rdy;

  // --------------------------------------------------
  // datapath
  // --------------------------------------------------

  muldiv_pkg::muldiv_op_e op_q;
  logic                   neg_q;
  // multiplicand moves left, multiplier moves right
  logic [2*WIDTH-1:0]     mcand_q;
  logic [WIDTH-1:0]       mplier_q;
  logic [2*WIDTH-1:0]     prod_q;

  logic             req_signed;
  logic [WIDTH-1:0] a_mag;
  logic [WIDTH-1:0] b_mag;

  assign req_signed = muldiv_pkg::is_signed_op(req_op);
  assign a_mag = (req_signed && req_a[WIDTH-1]) ? (~req_a + 1'b1) : req_a;
  assign b_mag = (req_signed && req_b[WIDTH-1]) ? (~req_b + 1'b1) : req_b;

  // negate the whole product when the signs differ
  assign resp_result = neg_q ? (~prod_q + 1'b1) : prod_q;
  assign resp_op     = op_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= muldiv_pkg::st_idle;
      count <= '0;
    end else begin
      case (state)
        muldiv_pkg::st_idle: begin
          if (req_go) begin
            state <= muldiv_pkg::st_calc;
            count <= '0;
          end
        end
        muldiv_pkg::st_calc: begin
          if (count == CNT_W'(WIDTH - 1)) begin
            state <= muldiv_pkg::st_done;
          end
          count <= count + CNT_W'(1);
        end
        muldiv_pkg::st_done: begin
          if (resp_go) begin
            state <= muldiv_pkg::st_idle;
          end
        end
        default: state <= muldiv_pkg::st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (req_go) begin
      op_q     <= req_op;
      neg_q    <= req_signed && (req_a[WIDTH-1] ^ req_b[WIDTH-1]);
      mcand_q  <= {{WIDTH{1'b0}}, a_mag};
      mplier_q <= b_mag;
      prod_q   <= '0;
    end else if (state == muldiv_pkg::st_calc) begin
      // add in the partial product for the current bit
      if (mplier_q[0]) begin
        prod_q <= prod_q + mcand_q;
      end
      mcand_q  <= mcand_q << 1;
      mplier_q <= mplier_q >> 1;
    end
  end

  // the product is offered WIDTH+1 clocks after the accept
  assert property (@(posedge clk) disable iff (reset)
    $rose(resp_val) |-> $past(req_go, WIDTH + 1));

endmodule

//--- muldiv_port_arbiter.sv
`timescale 1ns/1ps
// request steering and round-robin response arbitration
// divider and multiplier share one request and one response port

module muldiv_port_arbiter #(
  parameter int WIDTH = 32
) (
  input  logic                   clk,
  input  logic                   reset,
  // top request and response ports
  input  muldiv_pkg::muldiv_op_e req_op,
  input  logic [WIDTH-1:0]       req_a,
  input  logic [WIDTH-1:0]       req_b,
  input  logic                   req_val,
  output logic                   req_rdy,
  output muldiv_pkg::muldiv_op_e resp_op,
  output logic [2*WIDTH-1:0]     resp_result,
  output logic                   resp_val,
  input  logic                   resp_rdy,
  // divider side
  output muldiv_pkg::muldiv_op_e div_op,
  output logic [WIDTH-1:0]       div_a,
  output logic [WIDTH-1:0]       div_b,
  output logic                   div_val,
  input  logic                   div_rdy,
  input  logic [2*WIDTH-1:0]     div_resp_result,
  input  muldiv_pkg::muldiv_op_e div_resp_op,
  input  logic                   div_resp_val,
  output logic                   div_resp_rdy,
  // multiplier side
  output muldiv_pkg::muldiv_op_e mul_op,
  output logic [WIDTH-1:0]       mul_a,
  output logic [WIDTH-1:0]       mul_b,
  output logic                   mul_val,
  input  logic                   mul_rdy,
  input  logic [2*WIDTH-1:0]     mul_resp_result,
  input  muldiv_pkg::muldiv_op_e mul_resp_op,
  input  logic                   mul_resp_val,
  output logic                   mul_resp_rdy
);

  // --------------------------------------------------
  // request steering
  // --------------------------------------------------

  logic to_div;

  assign to_div  = muldiv_pkg::is_div_op(req_op);
  // payload fans out to both, only val is steered
  assign div_op  = req_op;
  assign div_a   = req_a;
  assign div_b   = req_b;
  assign mul_op  = req_op;
  assign mul_a   = req_a;
  assign mul_b   = req_b;
  assign div_val = req_val && to_div;
  assign mul_val = req_val && !to_div;
  assign req_rdy = to_div ? div_rdy : mul_rdy;

  // --------------------------------------------------
  // response arbitration
  // --------------------------------------------------

  logic last_mul_q;
  logic lock_q;
  logic grant_mul;

  always_comb begin
    if (lock_q) begin
      // stalled response keeps its grant
      grant_mul = last_mul_q;
    end else if (div_resp_val && mul_resp_val) begin
      grant_mul = !last_mul_q;
    end else if (mul_resp_val) begin
      grant_mul = 1'b1;
    end else if (div_resp_val) begin
      grant_mul = 1'b0;
    end else begin
      grant_mul = last_mul_q;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      last_mul_q <= 1'b0;
      lock_q     <= 1'b0;
    end else if (resp_val) begin
      last_mul_q <= grant_mul;
      lock_q     <= !resp_rdy;
    end
  end

  assign resp_val     = grant_mul ? mul_resp_val : div_resp_val;
  assign resp_op      = grant_mul ? mul_resp_op : div_resp_op;
  assign resp_result  = grant_mul ? mul_resp_result : div_resp_result;
  assign div_resp_rdy = resp_rdy && !grant_mul;
  assign mul_resp_rdy = resp_rdy && grant_mul;

  // a waiting response is not swapped for the other engine
  assert property (@(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> (resp_val && (grant_mul == $past(grant_mul))));

endmodule

//--- muldiv_unit.sv
`timescale 1ns/1ps
// iterative multiply/divide unit top level
// arbiter in front of one divider and one multiplier engine

module muldiv_unit #(
  parameter int WIDTH = 32
) (
  input  logic                   clk,
  input  logic                   reset,
  input  muldiv_pkg::muldiv_op_e req_op,
  input  logic [WIDTH-1:0]       req_a,
  input  logic [WIDTH-1:0]       req_b,
  input  logic                   req_val,
  output logic                   req_rdy,
  output muldiv_pkg::muldiv_op_e resp_op,
  output logic [2*WIDTH-1:0]     resp_result,
  output logic                   resp_val,
  input  logic                   resp_rdy
);

  // --------------------------------------------------
  // arbiter to divider
  // --------------------------------------------------

  muldiv_pkg::muldiv_op_e div_op;
  logic [WIDTH-1:0]       div_a;
  logic [WIDTH-1:0]       div_b;
  logic                   div_val;
  logic                   div_rdy;
  logic [2*WIDTH-1:0]     div_resp_result;
  muldiv_pkg::muldiv_op_e div_resp_op;
  logic                   div_resp_val;
  logic                   div_resp_rdy;

  // --------------------------------------------------
  // arbiter to multiplier
  // --------------------------------------------------

  muldiv_pkg::muldiv_op_e mul_op;
  logic [WIDTH-1:0]       mul_a;
  logic [WIDTH-1:0]       mul_b;
  logic                   mul_val;
  logic                   mul_rdy;
  logic [2*WIDTH-1:0]     mul_resp_result;
  muldiv_pkg::muldiv_op_e mul_resp_op;
  logic                   mul_resp_val;
  logic                   mul_resp_rdy;

  muldiv_port_arbiter #(.WIDTH(WIDTH)) arb_i (
    .clk             (clk),
    .reset           (reset),
    .req_op          (req_op),
    .req_a           (req_a),
    .req_b           (req_b),
    .req_val         (req_val),
    .req_rdy         (req_rdy),
    .resp_op         (resp_op),
    .resp_result     (resp_result),
    .resp_val        (resp_val),
    .resp_rdy        (resp_rdy),
    .div_op          (div_op),
    .div_a           (div_a),
    .div_b           (div_b),
    .div_val         (div_val),
    .div_rdy         (div_rdy),
    .div_resp_result (div_resp_result),
    .div_resp_op     (div_resp_op),
    .div_resp_val    (div_resp_val),
    .div_resp_rdy    (div_resp_rdy),
    .mul_op          (mul_op),
    .mul_a           (mul_a),
    .mul_b           (mul_b),
    .mul_val         (mul_val),
    .mul_rdy         (mul_rdy),
    .mul_resp_result (mul_resp_result),
    .mul_resp_op     (mul_resp_op),
    .mul_resp_val    (mul_resp_val),
    .mul_resp_rdy    (mul_resp_rdy)
  );

  int_div_iterative #(.WIDTH(WIDTH)) div_i (
    .clk         (clk),
    .reset       (reset),
    .req_op      (div_op),
    .req_a       (div_a),
    .req_b       (div_b),
    .req_val     (div_val),
    .req_rdy     (div_rdy),
    .resp_result (div_resp_result),
    .resp_op     (div_resp_op),
    .resp_val    (div_resp_val),
    .resp_rdy    (div_resp_rdy)
  );

  int_mul_iterative #(.WIDTH(WIDTH)) mul_i (
    .clk         (clk),
    .reset       (reset),
    .req_op      (mul_op),
    .req_a       (mul_a),
    .req_b       (mul_b),
    .req_val     (mul_val),
    .req_rdy     (mul_rdy),
    .resp_result (mul_resp_result),
    .resp_op     (mul_resp_op),
    .resp_val    (mul_resp_val),
    .resp_rdy    (mul_resp_rdy)
  );

endmodule

//--- tb_muldiv_ref.svh
// reference model for the multiply/divide unit
// expected products and {remainder, quotient} pairs, plus the compare task
`ifndef TB_MULDIV_REF_SVH
`define TB_MULDIV_REF_SVH

  // full product, operands extended by the op's signedness
  function automatic logic [RES_W-1:0] ref_mul(input muldiv_pkg::muldiv_op_e op,
                                               input logic [WIDTH-1:0]     a,
                                               input logic [WIDTH-1:0]     b);
    logic [RES_W-1:0] a_ext;
    logic [RES_W-1:0] b_ext;
    logic             sx;
    sx    = muldiv_pkg::is_signed_op(op);
    a_ext = {{WIDTH{sx & a[WIDTH-1]}}, a};
    b_ext = {{WIDTH{sx & b[WIDTH-1]}}, b};
    // low 2*WIDTH bits of the extended product are exact for both signednesses
    return a_ext * b_ext;
  endfunction

  // {remainder, quotient}, magnitudes first and signs applied after
  function automatic logic [RES_W-1:0] ref_div(input muldiv_pkg::muldiv_op_e op,
                                               input logic [WIDTH-1:0]     a,
                                               input logic [WIDTH-1:0]     b);
    logic             a_neg;
    logic             b_neg;
    logic [WIDTH-1:0] a_mag;
    logic [WIDTH-1:0] b_mag;
    logic [WIDTH-1:0] q_mag;
    logic [WIDTH-1:0] r_mag;
    a_neg = muldiv_pkg::is_signed_op(op) && a[WIDTH-1];
    b_neg = muldiv_pkg::is_signed_op(op) && b[WIDTH-1];
    a_mag = a_neg ? -a : a;
    b_mag = b_neg ? -b : b;
    if (b_mag == '0) begin
      // divide by zero: all-ones quotient, dividend as remainder
      q_mag = '1;
      r_mag = a_mag;
    end else begin
      q_mag = a_mag / b_mag;
      r_mag = a_mag % b_mag;
    end
    // quotient sign from both operands, remainder follows the dividend
    return {a_neg ? -r_mag : r_mag, (a_neg ^ b_neg) ? -q_mag : q_mag};
  endfunction

  // stop at the first value that differs
  task automatic check_value(input logic [RES_W-1:0] got,
                             input logic [RES_W-1:0] exp,
                             input string            what);
    if (got !== exp) begin
      $display("ERR %0d ns: %s got %h expected %h", $time, what, got, exp);
      $display(">>> FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

`endif

//--- tb_muldiv.sv
`timescale 1ns/1ps
// testbench for the iterative multiply/divide unit
// directed and random requests, per-engine scoreboard, random response stalls

module tb_muldiv;

  localparam int WIDTH         = 32;
  localparam int RES_W         = 2 * WIDTH;
  localparam int REQ_TIMEOUT   = 2000;
  localparam int DRAIN_TIMEOUT = 20000;
  localparam int NUM_RANDOM    = 400;

  localparam logic [WIDTH-1:0] ALL_ONES = '1;
  localparam logic [WIDTH-1:0] MOST_NEG = {1'b1, {(WIDTH - 1){1'b0}}};

  // --------------------------------------------------
  // DUT signals
  // --------------------------------------------------

  logic                   clk = 1'b0;
  logic                   reset;
  muldiv_pkg::muldiv_op_e req_op;
  logic [WIDTH-1:0]       req_a;
  logic [WIDTH-1:0]       req_b;
  logic                   req_val;
  logic                   req_rdy;
  muldiv_pkg::muldiv_op_e resp_op;
  logic [RES_W-1:0]       resp_result;
  logic                   resp_val;
  logic                   resp_rdy;

  // expected responses, one queue pair per engine since each answers in order
  logic [RES_W-1:0]       div_exp_res[$];
  muldiv_pkg::muldiv_op_e div_exp_op[$];
  logic [RES_W-1:0]       mul_exp_res[$];
  muldiv_pkg::muldiv_op_e mul_exp_op[$];

  int                     n_sent = 0;
  int                     n_recv = 0;
  // edges spent waiting for the last accept
  int                     last_wait = 0;
  logic                   bp_on = 1'b0;

  // response seen stalled on the previous edge
  logic                   stall_seen = 1'b0;
  muldiv_pkg::muldiv_op_e held_op;
  logic [RES_W-1:0]       held_result;

  `include "tb_muldiv_ref.svh"

  always #5 clk = ~clk;

  muldiv_unit #(.WIDTH(WIDTH)) dut_i (
    .clk         (clk),
    .reset       (reset),
    .req_op      (req_op),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_op     (resp_op),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

  // --------------------------------------------------
  // helpers
  // --------------------------------------------------

  task automatic abort_run(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1, "run aborted");
  endtask

  function automatic logic [RES_W-1:0] expected_result(input muldiv_pkg::muldiv_op_e op,
                                                       input logic [WIDTH-1:0]     a,
                                                       input logic [WIDTH-1:0]     b);
    if (muldiv_pkg::is_div_op(op)) begin
      return ref_div(op, a, b);
    end
    return ref_mul(op, a, b);
  endfunction

  // corner values show up often, the rest is plain random
  function automatic logic [WIDTH-1:0] pick_operand();
    int sel;
    sel = $urandom_range(0, 9);
    case (sel)
      0: return '0;
      1: return WIDTH'(1);
      2: return ALL_ONES;
      3: return MOST_NEG;
      4: return WIDTH'($urandom_range(0, 15));
      default: return WIDTH'($urandom());
    endcase
  endfunction

  // called at a falling edge, returns at the falling edge after the accept
  task automatic send_req(input muldiv_pkg::muldiv_op_e op,
                          input logic [WIDTH-1:0]     a,
                          input logic [WIDTH-1:0]     b);
    logic accepted;
    req_op    = op;
    req_a     = a;
    req_b     = b;
    req_val   = 1'b1;
    accepted  = 1'b0;
    last_wait = 0;
    while (!accepted) begin
      @(posedge clk);
      last_wait++;
      if (req_rdy) begin
        accepted = 1'b1;
      end else if (last_wait >= REQ_TIMEOUT) begin
        abort_run($sformatf("timed out after %0d cycles waiting for req_rdy on %s",
                            last_wait, op.name()));
      end
    end
    if (muldiv_pkg::is_div_op(op)) begin
      div_exp_res.push_back(expected_result(op, a, b));
      div_exp_op.push_back(op);
    end else begin
      mul_exp_res.push_back(expected_result(op, a, b));
      mul_exp_op.push_back(op);
    end
    n_sent++;
    @(negedge clk);
    req_val = 1'b0;
  endtask

  task automatic send_mul_pair(input logic [WIDTH-1:0] a, input logic [WIDTH-1:0] b);
    send_req(muldiv_pkg::op_mul, a, b);
    send_req(muldiv_pkg::op_mulu, a, b);
  endtask

  task automatic send_div_pair(input logic [WIDTH-1:0] a, input logic [WIDTH-1:0] b);
    send_req(muldiv_pkg::op_div, a, b);
    send_req(muldiv_pkg::op_divu, a, b);
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (div_exp_res.size() != 0 || mul_exp_res.size() != 0) begin
      @(negedge clk);
      cycles++;
      if (cycles >= DRAIN_TIMEOUT) begin
        abort_run($sformatf("%0d responses still missing after %0d cycles",
                            div_exp_res.size() + mul_exp_res.size(), cycles));
      end
    end
  endtask

  // pop the matching engine's oldest expectation and compare
  task automatic take_response();
    logic [RES_W-1:0]       exp_res;
    muldiv_pkg::muldiv_op_e exp_op;
    if (muldiv_pkg::is_div_op(resp_op)) begin
      if (div_exp_res.size() == 0) begin
        abort_run("divider response arrived with no divide outstanding");
      end else begin
        exp_res = div_exp_res.pop_front();
        exp_op  = div_exp_op.pop_front();
      end
    end else begin
      if (mul_exp_res.size() == 0) begin
        abort_run("multiplier response arrived with no multiply outstanding");
      end else begin
        exp_res = mul_exp_res.pop_front();
        exp_op  = mul_exp_op.pop_front();
      end
    end
    check_value(RES_W'(resp_op), RES_W'(exp_op),
                $sformatf("resp_op of response %0d", n_recv));
    check_value(resp_result, exp_res,
                $sformatf("%s result of response %0d", resp_op.name(), n_recv));
    n_recv++;
  endtask

  // --------------------------------------------------
  // response monitor
  // --------------------------------------------------

  always @(posedge clk) begin
    if (!reset) begin
      // a stalled response must still be offered unchanged
      if (stall_seen) begin
        check_value(RES_W'(resp_val), RES_W'(1), "resp_val dropped while stalled");
        check_value(RES_W'(resp_op), RES_W'(held_op), "resp_op changed while stalled");
        check_value(resp_result, held_result, "resp_result changed while stalled");
      end
      stall_seen  = resp_val && !resp_rdy;
      held_op     = resp_op;
      held_result = resp_result;
      if (resp_val && resp_rdy) begin
        take_response();
      end
    end
  end

  // --------------------------------------------------
  // response back-pressure
  // --------------------------------------------------

  initial begin
    int   stall_left;
    logic stall_now;
    stall_left = 0;
    resp_rdy   = 1'b1;
    forever begin
      // decide on the rising edge, drive on the falling edge
      @(posedge clk);
      if (stall_left > 0) begin
        stall_left--;
        stall_now = 1'b1;
      end else if (bp_on && $urandom_range(0, 3) == 0) begin
        stall_left = $urandom_range(0, 11);
        stall_now  = 1'b1;
      end else begin
        stall_now = 1'b0;
      end
      @(negedge clk);
      resp_rdy = !stall_now;
    end
  end

  // --------------------------------------------------
  // stimulus
  // --------------------------------------------------

  initial begin
    muldiv_pkg::muldiv_op_e op;
    int                     gap;
    void'($urandom(32'h29bd733a));
    reset   = 1'b1;
    req_op  = muldiv_pkg::op_mul;
    req_a   = '0;
    req_b   = '0;
    req_val = 1'b0;
    repeat (16) @(negedge clk);
    reset = 1'b0;

    // idle after reset
    @(posedge clk);
    check_value(RES_W'(req_rdy), RES_W'(1), "req_rdy after reset");
    check_value(RES_W'(resp_val), RES_W'(0), "resp_val after reset");
    @(negedge clk);

    // directed multiplies, signed and unsigned each
    send_mul_pair('0, WIDTH'(12345));
    send_mul_pair(WIDTH'(1), ALL_ONES);
    send_mul_pair(ALL_ONES, ALL_ONES);
    send_mul_pair(MOST_NEG, MOST_NEG);
    send_mul_pair(MOST_NEG, ALL_ONES);
    send_mul_pair(WIDTH'(-7), WIDTH'(9));
    send_mul_pair(WIDTH'(123456789), WIDTH'(-987));
    send_mul_pair(~MOST_NEG, WIDTH'(-2));
    wait_drain();

    // directed divides including zero divisor and overflow
    send_div_pair(WIDTH'(-100), WIDTH'(7));
    send_div_pair(WIDTH'(100), WIDTH'(-7));
    send_div_pair(WIDTH'(-100), WIDTH'(-7));
    send_div_pair(WIDTH'(100), WIDTH'(7));
    send_div_pair(WIDTH'(55), '0);
    send_div_pair(WIDTH'(-55), '0);
    send_div_pair(MOST_NEG, ALL_ONES);
    send_div_pair(WIDTH'(3), WIDTH'(10));
    send_div_pair(WIDTH'(-3), WIDTH'(10));
    send_div_pair(ALL_ONES, WIDTH'(2));
    wait_drain();

    // both engines busy together, in both issue orders
    send_req(muldiv_pkg::op_div, 32'h1234_5678, 32'd7);
    send_req(muldiv_pkg::op_mulu, 32'hdead_beef, 32'h0bad_f00d);
    check_value(RES_W'(last_wait), RES_W'(1), "multiply held back by a busy divide");
    wait_drain();
    send_req(muldiv_pkg::op_mul, 32'h8000_0001, 32'hffff_fff3);
    send_req(muldiv_pkg::op_divu, 32'hffff_0000, 32'h0000_0013);
    check_value(RES_W'(last_wait), RES_W'(1), "divide held back by a busy multiply");
    wait_drain();

    // back-to-back requests under response stalls
    bp_on = 1'b1;
    for (int i = 0; i < 60; i++) begin
      op = muldiv_pkg::muldiv_op_e'(2'(i % 4));
      send_req(op, pick_operand(), pick_operand());
    end
    wait_drain();

    // random ops with random gaps, stalls still on
    for (int i = 0; i < NUM_RANDOM; i++) begin
      op = muldiv_pkg::muldiv_op_e'(2'($urandom_range(0, 3)));
      send_req(op, pick_operand(), pick_operand());
      gap = ($urandom_range(0, 1) == 0) ? 0 : int'($urandom_range(1, 6));
      repeat (gap) @(negedge clk);
    end
    bp_on = 1'b0;
    wait_drain();

    // every request answered, so nothing may still be offered
    if (!resp_val) begin
      $display(">>> PASS");
      $finish;
    end else begin
      abort_run($sformatf("a response is still offered after all %0d requests were answered",
                          n_sent));
    end
  end

endmodule

//--- all.f
+incdir+.
muldiv_pkg.sv
int_div_iterative.sv
int_mul_iterative.sv
muldiv_port_arbiter.sv
muldiv_unit.sv
tb_muldiv.sv

//--- Makefile
# Verilator build for the multiply/divide unit testbench
# every failing run ends in $fatal, so the run target fails with the simulator

VERILATOR ?= verilator
TOP       ?= tb_muldiv
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST)) tb_muldiv_ref.svh
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
